// ==== hdl/bg_params.svh ====
`ifndef BG_PARAMS_SVH
`define BG_PARAMS_SVH

// visible pixels on one scan line
`define BG_SCREEN_WIDTH 160

// background map sits at the top of the 8 KB video memory
`define BG_MAP_BASE 13'h1800

`define BG_MAP_TILES 32
`define BG_TILE_PIXELS 8

`endif

// ==== hdl/bg_pkg.sv ====
`default_nettype none

package bg_pkg;

	// byte address into the 8 KB video memory
	typedef logic [12:0] vram_addr_t;

	typedef logic [7:0] tile_byte_t; // map entry or one plane byte

	typedef logic [1:0] color_idx_t; // high plane bit, then low plane bit

	typedef logic [1:0] shade_t;

	typedef logic [7:0] pixel_x_t; // also used for line number and scroll values

	typedef enum logic [2:0] {
		IDLE,
		MAP_ADDR,
		MAP_DATA,
		LO_ADDR,
		LO_DATA,
		HI_ADDR,
		HI_DATA,
		WAIT_LOAD
	} fetch_state_t;

endpackage

`default_nettype wire

// ==== hdl/bg_tile_fetcher.sv ====
`default_nettype none
`include "bg_params.svh"

module bg_tile_fetcher (
		input  logic clkpipe,
		input  logic rst,
		input  logic line_start,
		input  bg_pkg::pixel_x_t ly,
		input  bg_pkg::pixel_x_t scy,
		input  bg_pkg::pixel_x_t scx,
		input  bg_pkg::tile_byte_t md,
		input  logic line_done,
		output bg_pkg::vram_addr_t vram_addr,
		output logic vram_rd,
		output logic latch_lo,
		output logic latch_hi,
		output logic load,
		output logic shift
	);

	import bg_pkg::*;

	// one extra tile covers the pixels lost to fine scroll
	localparam int TILES_PER_LINE = `BG_SCREEN_WIDTH / `BG_TILE_PIXELS + 1;
	localparam logic [4:0] LAST_TILE = 5'(TILES_PER_LINE - 1);
	localparam logic [4:0] TILE_LIMIT = 5'(TILES_PER_LINE);
	localparam vram_addr_t MAP_BASE = vram_addr_t'(`BG_MAP_BASE);
	localparam vram_addr_t MAP_STRIDE = vram_addr_t'(`BG_MAP_TILES);
	localparam logic [3:0] TILE_SHIFTS = 4'(`BG_TILE_PIXELS);

	fetch_state_t state;
	fetch_state_t state_nxt;
	tile_byte_t tile_num;
	logic [4:0] tile_cnt; // tiles already handed to the shifter
	logic [3:0] shift_cnt; // shifts left in the tile now on screen
	pixel_x_t y_sum;
	logic [4:0] map_col;
	vram_addr_t map_addr;
	vram_addr_t plane_addr;

	assign y_sum = ly + scy; // wraps at 256 like the map
	assign map_col = scx[7:3] + tile_cnt; // coarse column wraps at 32 tiles

	assign map_addr = MAP_BASE + vram_addr_t'(y_sum[7:3]) * MAP_STRIDE
		+ vram_addr_t'(map_col);

	// 16 bytes per tile, two per row, low plane first
	assign plane_addr = {1'b0, tile_num, y_sum[2:0], state == HI_ADDR};

	assign vram_rd = (state == MAP_ADDR) || (state == LO_ADDR) || (state == HI_ADDR);
	assign vram_addr = (state == MAP_ADDR) ? map_addr : plane_addr;
	assign latch_lo = state == LO_DATA;
	assign latch_hi = state == HI_DATA;
	assign shift = shift_cnt != 4'd0;

	// the first tile loads into an empty shifter, later ones on the eighth shift
	assign load = (state == WAIT_LOAD) && (tile_cnt != TILE_LIMIT) && (shift_cnt <= 4'd1);

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (line_start) begin
					state_nxt = MAP_ADDR;
				end
			end
			MAP_ADDR: state_nxt = MAP_DATA;
			MAP_DATA: state_nxt = LO_ADDR;
			LO_ADDR: state_nxt = LO_DATA;
			LO_DATA: state_nxt = HI_ADDR;
			HI_ADDR: state_nxt = HI_DATA;
			HI_DATA: state_nxt = WAIT_LOAD;
			WAIT_LOAD: begin
				// after the last tile it parks here until the line ends
				if (load && tile_cnt != LAST_TILE) begin
					state_nxt = MAP_ADDR;
				end
			end
			default: state_nxt = IDLE;
		endcase
		if (line_done) begin
			state_nxt = IDLE;
		end
	end

	always_ff @(posedge clkpipe) begin
		if (rst) begin
			state <= IDLE;
			tile_cnt <= '0;
			shift_cnt <= '0;
		end else begin
			state <= state_nxt;
			if (line_start) begin
				tile_cnt <= '0;
			end else if (load) begin
				tile_cnt <= tile_cnt + 5'd1;
			end
			if (line_start || line_done) begin
				shift_cnt <= '0;
			end else if (load) begin
				shift_cnt <= TILE_SHIFTS; // load wins over the shift in the same cycle
			end else if (shift) begin
				shift_cnt <= shift_cnt - 4'd1;
			end
		end
	end

	always_ff @(posedge clkpipe) begin
		if (state == MAP_DATA) begin
			tile_num <= md; // map byte arrives one cycle after the read
		end
	end

endmodule

`default_nettype wire

// ==== hdl/bg_pixel_shifter.sv ====
`default_nettype none

module bg_pixel_shifter (
		input  logic clkpipe,
		input  logic rst,
		input  bg_pkg::tile_byte_t md,
		input  logic latch_lo,
		input  logic latch_hi,
		input  logic load,
		input  logic shift,
		output logic pix_a,
		output logic pix_b
	);

	import bg_pkg::*;

	tile_byte_t lo_hold;
	tile_byte_t hi_hold;
	tile_byte_t plane_lo;
	tile_byte_t plane_hi;

	// holding stage lets the next tile be fetched while this one shifts out
	always_ff @(posedge clkpipe) begin
		if (latch_lo) begin
			lo_hold <= md;
		end
		if (latch_hi) begin
			hi_hold <= md;
		end
	end

	always_ff @(posedge clkpipe) begin
		if (rst) begin
			plane_lo <= '0;
			plane_hi <= '0;
		end else if (load) begin
			plane_lo <= lo_hold;
			plane_hi <= hi_hold;
		end else if (shift) begin
			plane_lo <= {plane_lo[6:0], 1'b0}; // leftmost pixel is bit 7
			plane_hi <= {plane_hi[6:0], 1'b0};
		end
	end

	assign pix_a = plane_lo[7];
	assign pix_b = plane_hi[7];

endmodule

`default_nettype wire

// ==== hdl/bg_pixel_out.sv ====
`default_nettype none
`include "bg_params.svh"

module bg_pixel_out (
		input  logic clkpipe,
		input  logic rst,
		input  logic line_start,
		input  bg_pkg::pixel_x_t scx,
		input  bg_pkg::tile_byte_t bgp,
		input  logic pix_strobe,
		input  logic pix_a,
		input  logic pix_b,
		output logic pixel_valid,
		output bg_pkg::pixel_x_t pixel_x,
		output bg_pkg::shade_t shade,
		output logic line_done
	);

	import bg_pkg::*;

	localparam pixel_x_t LAST_X = pixel_x_t'(`BG_SCREEN_WIDTH - 1);

	logic active;
	logic [2:0] discard_cnt; // fine scroll pixels still to drop
	pixel_x_t col_cnt;
	color_idx_t idx;
	shade_t shade_sel;
	logic take;

	assign idx = {pix_b, pix_a};
	assign shade_sel = bgp[{idx, 1'b0} +: 2]; // index n picks bits 2n+1 and 2n
	assign take = active && pix_strobe && (discard_cnt == 3'd0);

	always_ff @(posedge clkpipe) begin
		if (rst) begin
			active <= 1'b0;
			discard_cnt <= '0;
			col_cnt <= '0;
			pixel_valid <= 1'b0;
			line_done <= 1'b0;
		end else begin
			pixel_valid <= take;
			line_done <= pixel_valid && (pixel_x == LAST_X);
			if (line_start) begin
				active <= 1'b1;
				discard_cnt <= scx[2:0];
				col_cnt <= '0;
			end else if (active && pix_strobe) begin
				if (discard_cnt != 3'd0) begin
					discard_cnt <= discard_cnt - 3'd1;
				end else begin
					col_cnt <= col_cnt + 8'd1;
					if (col_cnt == LAST_X) begin
						active <= 1'b0; // strobes past the last column are ignored
					end
				end
			end
		end
	end

	always_ff @(posedge clkpipe) begin
		if (take) begin
			shade <= shade_sel;
			pixel_x <= col_cnt;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/bg_pipeline_top.sv ====
`default_nettype none

module bg_pipeline_top (
		input  logic clkpipe,
		input  logic rst,
		input  logic line_start,
		input  bg_pkg::pixel_x_t ly,
		input  bg_pkg::pixel_x_t scy,
		input  bg_pkg::pixel_x_t scx,
		input  bg_pkg::tile_byte_t bgp,
		input  bg_pkg::tile_byte_t md,
		output bg_pkg::vram_addr_t vram_addr,
		output logic vram_rd,
		output logic pixel_valid,
		output bg_pkg::pixel_x_t pixel_x,
		output bg_pkg::shade_t shade,
		output logic line_done
	);

	logic latch_lo;
	logic latch_hi;
	logic load;
	logic shift;
	logic pix_a;
	logic pix_b;

	bg_tile_fetcher u_bg_tile_fetcher (
		.clkpipe   (clkpipe),
		.rst       (rst),
		.line_start(line_start),
		.ly        (ly),
		.scy       (scy),
		.scx       (scx),
		.md        (md),
		.line_done (line_done),
		.vram_addr (vram_addr),
		.vram_rd   (vram_rd),
		.latch_lo  (latch_lo),
		.latch_hi  (latch_hi),
		.load      (load),
		.shift     (shift)
	);

	bg_pixel_shifter u_bg_pixel_shifter (
		.clkpipe (clkpipe),
		.rst     (rst),
		.md      (md),
		.latch_lo(latch_lo),
		.latch_hi(latch_hi),
		.load    (load),
		.shift   (shift),
		.pix_a   (pix_a),
		.pix_b   (pix_b)
	);

	bg_pixel_out u_bg_pixel_out (
		.clkpipe    (clkpipe),
		.rst        (rst),
		.line_start (line_start),
		.scx        (scx),
		.bgp        (bgp),
		.pix_strobe (shift), // every shift cycle is one pixel
		.pix_a      (pix_a),
		.pix_b      (pix_b),
		.pixel_valid(pixel_valid),
		.pixel_x    (pixel_x),
		.shade      (shade),
		.line_done  (line_done)
	);

endmodule

`default_nettype wire

// ==== sim/bg_clock_gen.sv ====
`default_nettype none

module bg_clock_gen (
		output logic clkpipe,
		output logic rst
	);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clkpipe = 1'b0;
		forever #2 clkpipe = ~clkpipe; // 4 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clkpipe);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== sim/bg_pipeline_assertions.sv ====
`default_nettype none
`include "bg_params.svh"

module bg_pipeline_assertions (
		input wire logic clkpipe,
		input wire logic rst,
		input wire logic line_start,
		input wire logic vram_rd,
		input wire logic pixel_valid,
		input wire bg_pkg::pixel_x_t pixel_x,
		input wire logic line_done
	);

	timeunit 1ns;
	timeprecision 100ps;

	int assert_failures = 0; // read by the testbench at the end of the run
	logic seen_start;

	always_ff @(posedge clkpipe) begin
		if (rst) begin
			seen_start <= 1'b0;
		end else if (line_start) begin
			seen_start <= 1'b1;
		end
	end

	line_done_single: assert property (@(posedge clkpipe) disable iff (rst)
		line_done |=> !line_done) else begin
		$error("line_done stayed high for more than one cycle");
		assert_failures++;
	end

	pixel_x_in_range: assert property (@(posedge clkpipe) disable iff (rst)
		pixel_valid |-> (pixel_x < `BG_SCREEN_WIDTH)) else begin
		$error("pixel_x out of range while pixel_valid is high");
		assert_failures++;
	end

	// nothing may be fetched before the host starts the first line
	no_read_before_start: assert property (@(posedge clkpipe) disable iff (rst)
		!seen_start |-> !vram_rd) else begin
		$error("vram_rd went high before the first line_start");
		assert_failures++;
	end

endmodule

`default_nettype wire

// ==== sim/bg_pipeline_tb.sv ====
`default_nettype none
`include "bg_params.svh"

module bg_pipeline_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import bg_pkg::*;

	localparam int NUM_ROWS = 8;
	localparam int CYCLES_PER_ROW = 400;
	localparam int IDLE_CHECK_CYCLES = 10;
	localparam int WATCHDOG_CYCLES = NUM_ROWS * CYCLES_PER_ROW + IDLE_CHECK_CYCLES + 20;
	localparam int VRAM_BYTES = 8192;
	localparam logic [31:0] SEED = 32'h0864_4def;

	// columns are ly, scy, scx, bgp
	localparam logic [31:0] SCENARIOS [NUM_ROWS] = '{
		{8'h00, 8'h00, 8'h00, 8'hE4}, // map origin with the identity palette
		{8'h25, 8'h00, 8'h00, 8'hE4},
		{8'h0A, 8'h00, 8'h03, 8'hE4}, // fine scroll of three pixels
		{8'h32, 8'h00, 8'hF5, 8'hE4}, // coarse column runs past tile 31
		{8'h64, 8'hC8, 8'h0E, 8'hE4}, // ly + scy is 300 so the map row wraps
		{8'h8F, 8'hFF, 8'h07, 8'h1B},
		{8'h05, 8'h22, 8'h9C, 8'h72},
		{8'h90, 8'h80, 8'hFF, 8'hD2}
	};

	logic clkpipe;
	logic rst;
	logic line_start;
	pixel_x_t ly;
	pixel_x_t scy;
	pixel_x_t scx;
	tile_byte_t bgp;
	tile_byte_t md = 8'h00;
	vram_addr_t vram_addr;
	logic vram_rd;
	logic pixel_valid;
	pixel_x_t pixel_x;
	shade_t shade;
	logic line_done;

	tile_byte_t vram [VRAM_BYTES];

	bg_clock_gen u_bg_clock_gen (
		.clkpipe(clkpipe),
		.rst    (rst)
	);

	bg_pipeline_top u_bg_pipeline_top (
		.clkpipe    (clkpipe),
		.rst        (rst),
		.line_start (line_start),
		.ly         (ly),
		.scy        (scy),
		.scx        (scx),
		.bgp        (bgp),
		.md         (md),
		.vram_addr  (vram_addr),
		.vram_rd    (vram_rd),
		.pixel_valid(pixel_valid),
		.pixel_x    (pixel_x),
		.shade      (shade),
		.line_done  (line_done)
	);

	bind bg_pipeline_top bg_pipeline_assertions u_bg_pipeline_assertions (
		.clkpipe    (clkpipe),
		.rst        (rst),
		.line_start (line_start),
		.vram_rd    (vram_rd),
		.pixel_valid(pixel_valid),
		.pixel_x    (pixel_x),
		.line_done  (line_done)
	);

	// video memory answers one cycle after the read strobe
	always @(posedge clkpipe) begin
		if (vram_rd) begin
			md <= vram[vram_addr];
		end
	end

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		assert (expected == actual) else begin
			stop_with_failure($sformatf("CHECK FAILED at %0d ns: %s expected %0d, got %0d",
				$time, name, expected, actual));
		end
	endtask

	// background pixel at screen column x, straight from the map and tile data
	function automatic int expected_shade(input int row_ly, input int row_scy,
		input int row_scx, input int row_bgp, input int x);
		int y_bg;
		int x_bg;
		int map_at;
		int plane_at;
		int tile;
		int lo;
		int hi;
		int bit_pos;
		int idx;
		y_bg = (row_ly + row_scy) % 256;
		x_bg = (row_scx + x) % 256;
		map_at = `BG_MAP_BASE + (y_bg / `BG_TILE_PIXELS) * `BG_MAP_TILES
			+ (x_bg / `BG_TILE_PIXELS) % `BG_MAP_TILES;
		tile = int'(vram[map_at]);
		plane_at = tile * 16 + (y_bg % `BG_TILE_PIXELS) * 2;
		lo = int'(vram[plane_at]);
		hi = int'(vram[plane_at + 1]);
		bit_pos = 7 - x_bg % `BG_TILE_PIXELS; // leftmost pixel sits in bit 7
		idx = ((hi >> bit_pos) & 1) * 2 + ((lo >> bit_pos) & 1);
		return (row_bgp >> (2 * idx)) & 3;
	endfunction

	task automatic run_line(input int row);
		int s_ly;
		int s_scy;
		int s_scx;
		int s_bgp;
		int n;
		s_ly = int'(SCENARIOS[row][31:24]);
		s_scy = int'(SCENARIOS[row][23:16]);
		s_scx = int'(SCENARIOS[row][15:8]);
		s_bgp = int'(SCENARIOS[row][7:0]);
		@(posedge clkpipe);
		ly <= SCENARIOS[row][31:24];
		scy <= SCENARIOS[row][23:16];
		scx <= SCENARIOS[row][15:8];
		bgp <= SCENARIOS[row][7:0];
		line_start <= 1'b1;
		@(posedge clkpipe);
		line_start <= 1'b0;
		n = 0;
		while (n < `BG_SCREEN_WIDTH) begin
			@(negedge clkpipe);
			check_value("line_done", 0, int'(line_done));
			if (n > 0) begin
				check_value("pixel_valid", 1, int'(pixel_valid)); // no gaps once started
			end
			if (pixel_valid) begin
				check_value("pixel_x", n, int'(pixel_x));
				check_value("shade", expected_shade(s_ly, s_scy, s_scx, s_bgp, n), int'(shade));
				n++;
			end
		end
		@(negedge clkpipe);
		check_value("line_done", 1, int'(line_done));
		check_value("pixel_valid", 0, int'(pixel_valid));
		@(negedge clkpipe);
		check_value("line_done", 0, int'(line_done));
		check_value("pixel_valid", 0, int'(pixel_valid));
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clkpipe);
		stop_with_failure("Timeout: a scan line never finished within the watchdog limit");
	end

	initial begin
		line_start = 1'b0;
		ly = '0;
		scy = '0;
		scx = '0;
		bgp = '0;
		void'($urandom(SEED));
		for (int a = 0; a < VRAM_BYTES; a++) begin
			vram[a] = 8'($urandom);
		end

		@(negedge clkpipe);
		while (rst) begin
			@(negedge clkpipe);
		end
		// the pipeline must sit still until the first line starts
		repeat (IDLE_CHECK_CYCLES) begin
			@(negedge clkpipe);
			check_value("vram_rd", 0, int'(vram_rd));
			check_value("pixel_valid", 0, int'(pixel_valid));
			check_value("line_done", 0, int'(line_done));
		end

		for (int r = 0; r < NUM_ROWS; r++) begin
			run_line(r);
		end

		if (u_bg_pipeline_top.u_bg_pipeline_assertions.assert_failures == 0) begin
			$display("No errors");
			$finish;
		end else begin
			stop_with_failure("a bound assertion failed during the run");
		end
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+hdl
hdl/bg_pkg.sv
hdl/bg_tile_fetcher.sv
hdl/bg_pixel_shifter.sv
hdl/bg_pixel_out.sv
hdl/bg_pipeline_top.sv
sim/bg_clock_gen.sv
sim/bg_pipeline_assertions.sv
sim/bg_pipeline_tb.sv

// ==== Makefile ====
# Verilator build and run of the background pipeline testbench

VERILATOR ?= verilator
TOP       ?= bg_pipeline_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then \
		echo "TEST FAILED"; exit 1; \
	elif grep -q "No errors" $(LOG); then \
		echo "TEST PASSED"; \
	else \
		echo "TEST FAILED: no result in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
